//--- CoreDefs.sv
`default_nettype none

package CoreDefs;

    // ---------------------------------------------------------------------
    // Datapath widths
    // ---------------------------------------------------------------------

    localparam int DATA_WIDTH     = 32; // Data, address and instruction width
    localparam int REG_ADDR_WIDTH = 5;  // Register index width

    // ---------------------------------------------------------------------
    // Configuration and instruction cache geometry
    // ---------------------------------------------------------------------

    localparam int RV_ICACHE_ON       = 1;  // 1 = L1 instruction cache in place
    localparam int ICACHE_LINES       = 16; // One word per line
    localparam int ICACHE_INDEX_WIDTH = 4;  // log2 of line count
    localparam int ICACHE_TAG_WIDTH   = DATA_WIDTH - ICACHE_INDEX_WIDTH - 2; // Minus byte offset

    // ---------------------------------------------------------------------
    // RV32I major opcodes
    // ---------------------------------------------------------------------

    localparam logic [6:0] OP_LUI    = 7'b0110111; // Load upper immediate
    localparam logic [6:0] OP_OPIMM  = 7'b0010011; // Register-immediate ALU
    localparam logic [6:0] OP_OP     = 7'b0110011; // Register-register ALU
    localparam logic [6:0] OP_LOAD   = 7'b0000011; // LW
    localparam logic [6:0] OP_STORE  = 7'b0100011; // SW
    localparam logic [6:0] OP_BRANCH = 7'b1100011; // BEQ, BNE
    localparam logic [6:0] OP_JAL    = 7'b1101111; // Jump and link

    // ALU operation select
    typedef enum logic [2:0] {
        ALU_ADD   = 3'd0, // a + b
        ALU_SUB   = 3'd1, // a - b, also branch compare
        ALU_AND   = 3'd2,
        ALU_OR    = 3'd3,
        ALU_XOR   = 3'd4,
        ALU_SLT   = 3'd5, // Signed less than
        ALU_PASSB = 3'd6  // Result is b, used by LUI
    } AluOp;

endpackage

`default_nettype wire

//--- RegisterFile.sv
`timescale 1ns/1ps
`default_nettype none

module RegisterFile
    import CoreDefs::*;
(
    input  logic                      i_clock,   // Clock
    input  logic                      i_reset,   // Reset
    input  logic [REG_ADDR_WIDTH-1:0] i_rs1Addr, // Read port 1 index
    input  logic [REG_ADDR_WIDTH-1:0] i_rs2Addr, // Read port 2 index
    input  logic [REG_ADDR_WIDTH-1:0] i_rdAddr,  // Write index
    input  logic [DATA_WIDTH-1:0]     i_rdData,  // Write data
    input  logic                      i_we,      // Write enable
    output logic [DATA_WIDTH-1:0]     o_rs1Data, // Read data 1
    output logic [DATA_WIDTH-1:0]     o_rs2Data); // Read data 2

    logic [DATA_WIDTH-1:0] regs [2**REG_ADDR_WIDTH]; // x0..x31

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            for (int i = 0; i < 2**REG_ADDR_WIDTH; i++)
                regs[i] <= '0;                       // Clear whole file
        end
        else if (i_we && (i_rdAddr != '0))           // x0 is hardwired
            regs[i_rdAddr] <= i_rdData;
    end

    assign o_rs1Data = (i_rs1Addr == '0) ? '0 : regs[i_rs1Addr]; // Comb read
    assign o_rs2Data = (i_rs2Addr == '0) ? '0 : regs[i_rs2Addr];

endmodule

`default_nettype wire

//--- Alu.sv
`timescale 1ns/1ps
`default_nettype none

module Alu
    import CoreDefs::*;
(
    input  AluOp                  i_op,     // Operation select
    input  logic [DATA_WIDTH-1:0] i_a,      // Operand A
    input  logic [DATA_WIDTH-1:0] i_b,      // Operand B
    output logic [DATA_WIDTH-1:0] o_result, // Result
    output logic                  o_zero);  // Result is zero

    logic signedLess; // Signed compare for SLT

    assign signedLess = $signed(i_a) < $signed(i_b);

    always_comb begin
        case (i_op)
            ALU_ADD:   o_result = i_a + i_b;
            ALU_SUB:   o_result = i_a - i_b;
            ALU_AND:   o_result = i_a & i_b;
            ALU_OR:    o_result = i_a | i_b;
            ALU_XOR:   o_result = i_a ^ i_b;
            ALU_SLT:   o_result = {{(DATA_WIDTH-1){1'b0}}, signedLess}; // 0 or 1
            ALU_PASSB: o_result = i_b;
            default:   o_result = '0;                                  // Unused code
        endcase
    end

    // BEQ and BNE look at this after a SUB
    assign o_zero = (o_result == '0);

endmodule

`default_nettype wire

//--- CoreSC.sv
`timescale 1ns/1ps
`default_nettype none

module CoreSC
    import CoreDefs::*;
(
    input  logic                  i_clock,     // Clock
    input  logic                  i_reset,     // Reset
    input  logic [DATA_WIDTH-1:0] i_inst,      // Fetched instruction
    input  logic                  i_instBusy,  // Instruction bus busy
    input  logic [DATA_WIDTH-1:0] i_dataRdata, // Load data
    input  logic                  i_dataBusy,  // Data bus busy
    output logic [DATA_WIDTH-1:0] o_instAddr,  // Fetch address
    output logic                  o_instRe,    // Fetch request
    output logic [DATA_WIDTH-1:0] o_dataAddr,  // Data address
    output logic                  o_dataRe,    // Load request
    output logic                  o_dataWe,    // Store request
    output logic [3:0]            o_dataBe,    // Byte enables
    output logic [DATA_WIDTH-1:0] o_dataWdata); // Store data

    // ---------------------------------------------------------------------
    // Program counter and fetch
    // ---------------------------------------------------------------------

    logic [DATA_WIDTH-1:0] pc;      // Current instruction address
    logic [DATA_WIDTH-1:0] pcPlus4; // Sequential successor
    logic [DATA_WIDTH-1:0] pcNext;  // Selected next PC
    logic                  running; // Low while in reset
    logic                  instReady; // Fetch completes this cycle
    logic                  stall;   // Hold PC and register writes
    logic                  retire;  // Instruction completes this edge

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            pc      <= '0;      // Boot address
            running <= 1'b0;
        end
        else begin
            running <= 1'b1;    // Start fetching after reset
            if (retire)
                pc <= pcNext;
        end
    end

    assign o_instAddr = pc;
    assign o_instRe   = running;
    assign pcPlus4    = pc + 32'd4;

    // ---------------------------------------------------------------------
    // Decode
    // ---------------------------------------------------------------------

    logic [6:0]                opcode;
    logic [2:0]                funct3;
    logic [REG_ADDR_WIDTH-1:0] rs1, rs2, rd;
    logic [DATA_WIDTH-1:0]     immI, immS, immB, immU, immJ;
    logic isLui, isOpImm, isOp, isLoad, isStore, isBranch, isJal;
    logic regWrite;                 // Instruction writes rd
    AluOp aluOp;
    logic [DATA_WIDTH-1:0]     aluB; // Second ALU operand
    logic [DATA_WIDTH-1:0]     rs1Data, rs2Data, aluResult, rdData;

    assign opcode = i_inst[6:0];
    assign rd     = i_inst[11:7];
    assign funct3 = i_inst[14:12];
    assign rs1    = i_inst[19:15];
    assign rs2    = i_inst[24:20];

    assign immI = {{20{i_inst[31]}}, i_inst[31:20]};
    assign immS = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
    assign immB = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
    assign immU = {i_inst[31:12], 12'b0};
    assign immJ = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

    assign isLui    = (opcode == OP_LUI);
    assign isOpImm  = (opcode == OP_OPIMM);
    assign isOp     = (opcode == OP_OP);
    assign isLoad   = (opcode == OP_LOAD);
    assign isStore  = (opcode == OP_STORE);
    assign isBranch = (opcode == OP_BRANCH);
    assign isJal    = (opcode == OP_JAL);
    assign regWrite = isLui | isOpImm | isOp | isLoad | isJal;

    // Map funct3 to ALU op for OP and OP-IMM
    function automatic AluOp aluFromFunct3(input logic [2:0] f3, input logic sub);
        case (f3)
            3'b000:  aluFromFunct3 = sub ? ALU_SUB : ALU_ADD;
            3'b010:  aluFromFunct3 = ALU_SLT;
            3'b100:  aluFromFunct3 = ALU_XOR;
            3'b110:  aluFromFunct3 = ALU_OR;
            3'b111:  aluFromFunct3 = ALU_AND;
            default: aluFromFunct3 = ALU_ADD; // Outside supported subset
        endcase
    endfunction

    always_comb begin
        aluOp = ALU_ADD;            // Loads, stores, default
        aluB  = immI;
        if (isOp) begin
            aluOp = aluFromFunct3(funct3, i_inst[30]); // funct7 bit 5 selects SUB
            aluB  = rs2Data;
        end
        else if (isOpImm)
            aluOp = aluFromFunct3(funct3, 1'b0);       // No SUBI
        else if (isStore)
            aluB  = immS;
        else if (isBranch) begin
            aluOp = ALU_SUB;                           // Equality via zero flag
            aluB  = rs2Data;
        end
        else if (isLui) begin
            aluOp = ALU_PASSB;
            aluB  = immU;
        end
    end

    // ---------------------------------------------------------------------
    // Execute
    // ---------------------------------------------------------------------

    logic                  aluZero, branchTaken;

    RegisterFile
    regFile (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_rs1Addr (rs1),
        .i_rs2Addr (rs2),
        .i_rdAddr  (rd),
        .i_rdData  (rdData),
        .i_we      (retire & regWrite),   // Only on the retire edge
        .o_rs1Data (rs1Data),
        .o_rs2Data (rs2Data));

    Alu
    alu (
        .i_op     (aluOp),
        .i_a      (rs1Data),
        .i_b      (aluB),
        .o_result (aluResult),
        .o_zero   (aluZero));

    assign branchTaken = isBranch & (funct3[0] ? ~aluZero : aluZero); // BNE : BEQ

    always_comb begin
        if (isJal)
            pcNext = pc + immJ;
        else if (branchTaken)
            pcNext = pc + immB;
        else
            pcNext = pcPlus4;
    end

    assign rdData = isLoad ? i_dataRdata : (isJal ? pcPlus4 : aluResult); // Writeback mux

    // ---------------------------------------------------------------------
    // Memory access and stall
    // ---------------------------------------------------------------------

    assign instReady   = running & ~i_instBusy;        // Instruction is valid
    assign stall       = ~instReady | ((isLoad | isStore) & i_dataBusy);
    assign retire      = ~stall;

    assign o_dataAddr  = aluResult;
    assign o_dataRe    = instReady & isLoad;           // Only once fetch is done
    assign o_dataWe    = instReady & isStore;
    assign o_dataBe    = 4'b1111;                      // Word access only
    assign o_dataWdata = rs2Data;

    // A load and a store can never share one cycle on the data bus
    assert property (@(posedge i_clock) disable iff (i_reset) !(o_dataRe && o_dataWe));

    // Branch and jump targets must land on word boundaries
    assert property (@(posedge i_clock) disable iff (i_reset) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- InstL1Cache.sv
`timescale 1ns/1ps
`default_nettype none

module InstL1Cache
    import CoreDefs::*;
(
    input  logic                  i_clock,    // Clock
    input  logic                  i_reset,    // Reset
    input  logic [DATA_WIDTH-1:0] i_coreAddr, // Core fetch address
    input  logic                  i_coreRe,   // Core fetch request
    input  logic [DATA_WIDTH-1:0] i_busInst,  // Outer bus instruction
    input  logic                  i_busBusy,  // Outer bus busy
    output logic [DATA_WIDTH-1:0] o_coreInst, // Instruction to core
    output logic                  o_coreBusy, // Miss in progress
    output logic [DATA_WIDTH-1:0] o_busAddr,  // Outer bus address
    output logic                  o_busRe);   // Outer bus request

    typedef enum logic {
        IDLE, // Serving hits
        FILL  // Waiting on outer bus
    } State;

    State state;

    logic [ICACHE_TAG_WIDTH-1:0] tagArr  [ICACHE_LINES]; // Tag per line
    logic [DATA_WIDTH-1:0]       dataArr [ICACHE_LINES]; // One word per line
    logic [ICACHE_LINES-1:0]     validBits;

    logic [ICACHE_INDEX_WIDTH-1:0] coreIndex, fillIndex;
    logic [ICACHE_TAG_WIDTH-1:0]   coreTag, fillTag;
    logic [DATA_WIDTH-1:0]         fillAddr;  // Latched miss address
    logic                          hit;
    logic                          fillDone;  // Outer read completes

    assign coreIndex = i_coreAddr[ICACHE_INDEX_WIDTH+1:2];
    assign coreTag   = i_coreAddr[DATA_WIDTH-1 -: ICACHE_TAG_WIDTH];
    assign fillIndex = fillAddr[ICACHE_INDEX_WIDTH+1:2];
    assign fillTag   = fillAddr[DATA_WIDTH-1 -: ICACHE_TAG_WIDTH];

    assign hit      = validBits[coreIndex] && (tagArr[coreIndex] == coreTag);
    assign fillDone = (state == FILL) && !i_busBusy;

    // ---------------------------------------------------------------------
    // Core side
    // ---------------------------------------------------------------------

    assign o_coreInst = dataArr[coreIndex];   // Valid only on hit
    assign o_coreBusy = i_coreRe && !hit;     // Rises at once on miss

    // ---------------------------------------------------------------------
    // Miss FSM
    // ---------------------------------------------------------------------

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state     <= IDLE;
            validBits <= '0;                    // Everything invalid
        end
        else begin
            case (state)
                IDLE:
                    if (i_coreRe && !hit)
                        state <= FILL;          // Outer re from next cycle
                FILL:
                    if (fillDone) begin
                        validBits[fillIndex] <= 1'b1;
                        state                <= IDLE; // Retry hits next cycle
                    end
                default:
                    state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clock) begin
        if (state == IDLE && i_coreRe && !hit)
            fillAddr <= {i_coreAddr[DATA_WIDTH-1:2], 2'b00}; // Word aligned
        if (fillDone) begin
            tagArr[fillIndex]  <= fillTag;
            dataArr[fillIndex] <= i_busInst;
        end
    end

    assign o_busRe   = (state == FILL);
    assign o_busAddr = fillAddr;

    // Outer request must hold its address until the memory accepts it
    assert property (@(posedge i_clock) disable iff (i_reset)
        (o_busRe && i_busBusy) |=> (o_busRe && $stable(o_busAddr)));

endmodule

`default_nettype wire

//--- Processor.sv
`timescale 1ns/1ps
`default_nettype none

module Processor
    import CoreDefs::*;
(
    input  logic                  i_clock,     // Clock
    input  logic                  i_reset,     // Reset
    input  logic [DATA_WIDTH-1:0] i_instData,  // Instruction memory data
    input  logic                  i_instBusy,  // Instruction memory busy
    input  logic [DATA_WIDTH-1:0] i_dataRdata, // Data memory read data
    input  logic                  i_dataBusy,  // Data memory busy
    output logic [DATA_WIDTH-1:0] o_instAddr,  // Instruction memory address
    output logic                  o_instRe,    // Instruction memory read
    output logic [DATA_WIDTH-1:0] o_dataAddr,  // Data memory address
    output logic                  o_dataRe,    // Data memory read
    output logic                  o_dataWe,    // Data memory write
    output logic [3:0]            o_dataBe,    // Data memory byte enables
    output logic [DATA_WIDTH-1:0] o_dataWdata); // Data memory write data

    logic [DATA_WIDTH-1:0] coreInstAddr; // Core side instruction bus
    logic                  coreInstRe;
    logic [DATA_WIDTH-1:0] coreInst;
    logic                  coreInstBusy;

    // ---------------------------------------------------------------------
    // L1 instruction cache
    // ---------------------------------------------------------------------

    generate
        if (RV_ICACHE_ON == 1) begin : ICacheBlock
            InstL1Cache
            instL1Cache (
                .i_clock    (i_clock),
                .i_reset    (i_reset),
                .i_coreAddr (coreInstAddr),
                .i_coreRe   (coreInstRe),
                .i_busInst  (i_instData),
                .i_busBusy  (i_instBusy),
                .o_coreInst (coreInst),
                .o_coreBusy (coreInstBusy),
                .o_busAddr  (o_instAddr),
                .o_busRe    (o_instRe));
        end
        else begin : IBypassBlock
            assign o_instAddr   = coreInstAddr; // Straight to memory
            assign o_instRe     = coreInstRe;
            assign coreInst     = i_instData;
            assign coreInstBusy = i_instBusy;
        end
    endgenerate

    // ---------------------------------------------------------------------
    // Core with the data bus passed straight through
    // ---------------------------------------------------------------------

    CoreSC
    core (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_inst      (coreInst),
        .i_instBusy  (coreInstBusy),
        .i_dataRdata (i_dataRdata),
        .i_dataBusy  (i_dataBusy),
        .o_instAddr  (coreInstAddr),
        .o_instRe    (coreInstRe),
        .o_dataAddr  (o_dataAddr),
        .o_dataRe    (o_dataRe),
        .o_dataWe    (o_dataWe),
        .o_dataBe    (o_dataBe),
        .o_dataWdata (o_dataWdata));

endmodule

`default_nettype wire

//--- ProcessorTb.sv
`timescale 1ns/1ps
`default_nettype none

module ProcessorTb;

    localparam int          NUM_WRITES  = 12;
    localparam logic [31:0] POISON_ADDR = 32'h0000_01f0; // Skipped stores target this
    localparam logic [31:0] LOOP_FIRST  = 32'h0000_0074; // Word 29
    localparam logic [31:0] LOOP_LAST   = 32'h0000_0088; // Word 34

    logic        clock, reset;
    logic [31:0] instData, instAddr, dataRdata, dataAddr, dataWdata;
    logic        instBusy, instRe, dataBusy, dataRe, dataWe;
    logic [3:0]  dataBe;

    logic [31:0] instMem [64];        // Instruction image
    logic [31:0] dataMem [256];       // Data memory, starts at zero
    logic [31:0] expAddr [NUM_WRITES];
    logic [31:0] expData [NUM_WRITES];
    string       expName [NUM_WRITES];
    logic [31:0] rngState = 32'h412e_318f;
    logic [63:0] fetchedOnce;         // One bit per instruction word
    logic        fetchDone, inLoop;
    int          instHold, dataHold, progLen, expCount, writeCount, errorCount, cycleCount;
    int          loadCount;           // Completed loads

    Processor
    i_dut (
        .i_clock     (clock),
        .i_reset     (reset),
        .i_instData  (instData),
        .i_instBusy  (instBusy),
        .i_dataRdata (dataRdata),
        .i_dataBusy  (dataBusy),
        .o_instAddr  (instAddr),
        .o_instRe    (instRe),
        .o_dataAddr  (dataAddr),
        .o_dataRe    (dataRe),
        .o_dataWe    (dataWe),
        .o_dataBe    (dataBe),
        .o_dataWdata (dataWdata));

    // ---------------------------------------------------------------------
    // RV32I encoders and random source
    // ---------------------------------------------------------------------

    function automatic logic [31:0] rType(input logic [31:0] f7, f3, rd, rs1, rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] iType(input logic [31:0] op, f3, rd, rs1, imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] sType(input logic [31:0] rs2, rs1, imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011}; // SW
    endfunction

    function automatic logic [31:0] bType(input logic [31:0] f3, rs1, rs2, imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jType(input logic [31:0] rd, imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic logic [31:0] uType(input logic [31:0] rd, imm);
        return {imm[19:0], rd[4:0], 7'b0110111}; // LUI
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // Busy bursts of 1..4 cycles start on about a fifth of idle cycles
    function automatic int nextHold(input int hold);
        if (hold > 0)
            return hold - 1;
        rngState = xorshift(rngState);
        if (rngState % 5 != 0)
            return 0;
        rngState = xorshift(rngState);
        return 1 + int'(rngState % 4);
    endfunction

    task automatic emit(input logic [31:0] word);
        instMem[progLen] = word;
        progLen++;
    endtask

    task automatic expectWrite(input logic [31:0] addr, data, input string name);
        expAddr[expCount] = addr;
        expData[expCount] = data;
        expName[expCount] = name;
        expCount++;
    endtask

    // ---------------------------------------------------------------------
    // Clock, busy generation, memories
    // ---------------------------------------------------------------------

    initial clock = 1'b0;
    always #50 clock = ~clock;          // 100 ns period

    always @(posedge clock) begin
        #10;
        instHold = nextHold(instHold);
        dataHold = nextHold(dataHold);
        instBusy = (instHold > 0);
        dataBusy = (dataHold > 0);
        cycleCount++;
    end

    assign instData  = instMem[instAddr[7:2]];   // Combinational reads
    assign dataRdata = dataMem[dataAddr[9:2]];
    assign fetchDone = instRe && !instBusy;
    assign inLoop    = (instAddr >= LOOP_FIRST) && (instAddr <= LOOP_LAST);

    always @(posedge clock) begin
        if (reset)
            fetchedOnce <= '0;
        else if (fetchDone)
            fetchedOnce[instAddr[7:2]] <= 1'b1;
    end

    // Completed stores are checked against the ordered list
    always @(posedge clock) begin
        if (!reset && dataWe && !dataBusy) begin
            if (writeCount >= NUM_WRITES) begin
                errorCount++;
                $display("Unexpected extra store of %h to address %h", dataWdata, dataAddr);
            end
            else begin
                assert (dataAddr == expAddr[writeCount] && dataWdata == expData[writeCount])
                else begin
                    errorCount++;
                    $display("ERROR %s: expected %h <= %h, actual %h <= %h", expName[writeCount],
                             expAddr[writeCount], expData[writeCount], dataAddr, dataWdata);
                end
            end
            dataMem[dataAddr[9:2]] = dataWdata;
            writeCount <= writeCount + 1;
        end
    end

    always @(posedge clock) begin
        if (!reset && dataRe && !dataBusy)
            loadCount <= loadCount + 1;
    end

    // ---------------------------------------------------------------------
    // Protocol assertions
    // ---------------------------------------------------------------------

    assert property (@(posedge clock) disable iff (reset)
        (dataWe && dataBusy) |=> (dataWe && $stable(dataAddr) && $stable(dataWdata)))
    else begin
        errorCount++;
        $display("Store request changed while the data bus was busy");
    end

    assert property (@(posedge clock) disable iff (reset)
        (dataRe && dataBusy) |=> (dataRe && $stable(dataAddr)))
    else begin
        errorCount++;
        $display("Load request changed while the data bus was busy");
    end

    assert property (@(posedge clock) disable iff (reset)
        (dataRe || dataWe) |-> (dataBe == 4'b1111))
    else begin
        errorCount++;
        $display("ERROR BYTE_ENABLE: expected %h, actual %h", 4'b1111, dataBe);
    end

    assert property (@(posedge clock) disable iff (reset)
        (dataWe && !dataBusy) |-> (dataAddr != POISON_ADDR))
    else begin
        errorCount++;
        $display("A skipped instruction wrote the poison address");
    end

    assert property (@(posedge clock) disable iff (reset)
        (CoreDefs::RV_ICACHE_ON == 1 && fetchDone && inLoop) |-> !fetchedOnce[instAddr[7:2]])
    else begin
        errorCount++;
        $display("Loop instruction at %h was fetched from memory twice", instAddr);
    end

    assert property (@(posedge clock) (reset && cycleCount > 0) |-> (!instRe && !dataWe))
    else begin
        errorCount++;
        $display("Bus request seen while reset was held");
    end

    assert property (@(posedge clock) (instRe && fetchedOnce == '0) |-> (instAddr == 32'h0))
    else begin
        errorCount++;
        $display("First fetch after reset was not at address zero");
    end

    // ---------------------------------------------------------------------
    // Program, expected stores, run control
    // ---------------------------------------------------------------------

    initial begin
        int waitCycles;
        logic [31:0] a, b;
        reset = 1'b1;
        instBusy = 1'b0;
        dataBusy = 1'b0;
        foreach (instMem[i]) instMem[i] = '0;
        foreach (dataMem[i]) dataMem[i] = '0;
        emit(iType(32'h13, 0, 1, 0, 7));           // 0  addi x1, x0, 7
        emit(iType(32'h13, 0, 2, 0, -3));          // 1  addi x2, x0, -3
        emit(rType(0, 0, 3, 1, 2));                // 2  add
        emit(sType(3, 0, 32'h100));
        emit(rType(32, 0, 3, 1, 2));               // 4  sub
        emit(sType(3, 0, 32'h104));
        emit(rType(0, 7, 3, 1, 2));                // 6  and
        emit(sType(3, 0, 32'h108));
        emit(rType(0, 6, 3, 1, 2));                // 8  or
        emit(sType(3, 0, 32'h10c));
        emit(rType(0, 4, 3, 1, 2));                // 10 xor
        emit(sType(3, 0, 32'h110));
        emit(rType(0, 2, 3, 2, 1));                // 12 slt x3, x2, x1
        emit(sType(3, 0, 32'h114));
        emit(uType(4, 32'h12345));                 // 14 lui
        emit(iType(32'h13, 0, 4, 4, 32'h678));
        emit(sType(4, 0, 32'h118));
        emit(iType(32'h03, 2, 5, 0, 32'h118));     // 17 lw x5 back
        emit(iType(32'h13, 0, 5, 5, 100));
        emit(sType(5, 0, 32'h11c));
        emit(bType(0, 1, 1, 8));                   // 20 beq taken to 22
        emit(sType(1, 0, POISON_ADDR));
        emit(bType(1, 1, 1, 8));                   // 22 bne not taken
        emit(sType(2, 0, 32'h120));                // Fall-through marker
        emit(jType(6, 8));                         // 24 jal x6 to 26
        emit(sType(1, 0, POISON_ADDR));
        emit(sType(6, 0, 32'h124));                // Link value
        emit(iType(32'h13, 0, 7, 0, 0));           // 27 count
        emit(iType(32'h13, 0, 8, 0, 5));           // Limit
        emit(iType(32'h13, 0, 7, 7, 1));           // 29 loop body start
        emit(iType(32'h13, 0, 9, 9, 2));
        emit(rType(0, 4, 10, 9, 7));
        emit(rType(0, 0, 11, 11, 7));              // Running sum of count
        emit(iType(32'h13, 0, 12, 12, 3));
        emit(bType(1, 7, 8, -20));                 // 34 bne back to 29
        emit(sType(7, 0, 32'h128));
        emit(sType(11, 0, 32'h12c));
        emit(jType(0, 0));                         // 37 spin

        a = 32'd7;
        b = -32'sd3;
        expectWrite(32'h100, a + b, "ADD");
        expectWrite(32'h104, a - b, "SUB");
        expectWrite(32'h108, a & b, "AND");
        expectWrite(32'h10c, a | b, "OR");
        expectWrite(32'h110, a ^ b, "XOR");
        expectWrite(32'h114, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0, "SLT");
        expectWrite(32'h118, (32'h12345 << 12) + 32'h678, "LUI_ADDI");
        expectWrite(32'h11c, (32'h12345 << 12) + 32'h678 + 32'd100, "LOAD_STORE");
        expectWrite(32'h120, b, "BNE_FALLTHROUGH");
        expectWrite(32'h124, 32'd25 * 4, "JAL_LINK");  // Address after the jal
        expectWrite(32'h128, 32'd5, "LOOP_COUNT");
        expectWrite(32'h12c, 32'd1 + 2 + 3 + 4 + 5, "LOOP_SUM");

        repeat (3) @(posedge clock);
        #10 reset = 1'b0;
        waitCycles = 0;
        while (writeCount < NUM_WRITES && waitCycles < 5000) begin
            @(posedge clock);
            waitCycles++;
        end
        if (writeCount < NUM_WRITES) begin
            errorCount++;
            $display("Timeout after %0d cycles with %0d of %0d stores done",
                     waitCycles, writeCount, NUM_WRITES);
        end
        repeat (20) @(posedge clock);           // Catch stray stores
        if (loadCount != 1) begin
            errorCount++;
            $display("ERROR LOAD_COUNT: expected %0d, actual %0d", 1, loadCount);
        end
        $display("Stores: %0d of %0d, loads: %0d, errors: %0d",
                 writeCount, NUM_WRITES, loadCount, errorCount);
        if (errorCount == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
CoreDefs.sv
RegisterFile.sv
Alu.sv
CoreSC.sv
InstL1Cache.sv
Processor.sv
ProcessorTb.sv

//--- Makefile
# Verilator simulation of the Processor testbench

VERILATOR ?= verilator
TOP       ?= ProcessorTb
FLAGS     ?= --binary --timing --assert
BUILD_DIR ?= obj_dir
PASS_LINE := PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator, run, and check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR=$(VERILATOR) TOP=$(TOP) FLAGS='$(FLAGS)' BUILD_DIR=$(BUILD_DIR)"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f compile.f
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_LINE)"

clean:
	rm -rf $(BUILD_DIR)
